// ==== dma_subsystem.f ====
+incdir+logic
logic/dma_pkg.sv
logic/dma_cmd_port.sv
logic/dma_engine.sv
logic/bus_arbiter.sv
logic/mem_bank.sv
logic/dma_subsystem.sv
dv/tb_dma_subsystem.sv

// ==== dv/tb_dma_subsystem.sv ====
`include "dma_consts.svh"

module tb_dma_subsystem;

    localparam int PERIOD     = 20;
    localparam int NUM_ROUNDS = 20;
    localparam int NUM_CMDS   = 2 * NUM_ROUNDS + 1; // busy drops issue two.
    localparam int MAX_BLOCKS = `MEM_QWORDS;
    localparam int BLK_CYCLES = `MEM_WR_LAT + 1;
    localparam int IDX_W      = $clog2(`MEM_QWORDS);
    localparam int WATCHDOG_TIME =
        (NUM_CMDS * MAX_BLOCKS * BLK_CYCLES + NUM_ROUNDS * 400 + 1000) * PERIOD;

    logic                   clk;
    logic                   rst;
    logic                   cmd_req;
    logic [`WORD_SIZE-1:0]  cmd_addr;
    dma_pkg::dma_qword_u    cmd_data;
    logic                   intr_resolved;
    dma_pkg::dma_qword_u    dev_data;
    logic                   rd_en;
    logic [`WORD_SIZE-1:0]  rd_addr;
    logic [1:0]             intr;
    logic                   dev_next;
    logic                   rd_ready;
    logic [`QWORD_SIZE-1:0] rd_data;
    logic                   rd_valid;
    logic                   bg;

    logic [`QWORD_SIZE-1:0] model [`MEM_QWORDS];
    logic [`WORD_SIZE-1:0]  cur_addr;
    logic [31:0]            dev_count;
    int                     blk_count;
    int                     dev_pulses;

    dma_subsystem UUT (
        .clk           (clk),
        .rst           (rst),
        .cmd_req       (cmd_req),
        .cmd_addr      (cmd_addr),
        .cmd_data      (cmd_data),
        .intr_resolved (intr_resolved),
        .dev_data      (dev_data),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .intr          (intr),
        .dev_next      (dev_next),
        .rd_ready      (rd_ready),
        .rd_data       (rd_data),
        .rd_valid      (rd_valid),
        .bg            (bg)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("timeout: the run did not finish within %0d time units", WATCHDOG_TIME);
        stop_failed();
    end

    task automatic stop_failed();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic value_error(input string msg);
        $display("CHECK FAILED at time %0t: %s", $time, msg);
        stop_failed();
    endtask

    task automatic plain_error(input string msg);
        $display("%s", msg);
        stop_failed();
    endtask

    // device source and memory model, one step per block.
    always @(posedge clk) begin
        logic [`WORD_SIZE-1:0] blk_addr;
        if (!rst) begin
            assert (rd_ready == !bg)
            else value_error("rd_ready is not low exactly while bg is high");
            if (dev_next) begin
                blk_addr = cur_addr + `WORD_SIZE'(blk_count * `DMA_STEP);
                model[blk_addr[2 +: IDX_W]] = dev_data.raw;
                blk_count++;
                dev_pulses++;
                dev_count = dev_count + 1;
                dev_data.raw <= {dev_count, $urandom}; // counter above random bits.
            end
        end
    end

    task automatic issue_cmd(input logic [`WORD_SIZE-1:0] addr, input int len);
        dma_pkg::dma_qword_u word;
        word.raw     = {$urandom, $urandom};
        word.cmd.len = `WORD_SIZE'(len);
        @(posedge clk);
        cmd_req  <= 1'b1;
        cmd_addr <= addr;
        cmd_data <= word;
        @(posedge clk);
        cmd_req  <= 1'b0;
    endtask

    task automatic wait_bg();
        int n;
        n = 0;
        while (!bg) begin
            @(posedge clk);
            n++;
            if (n > 20) begin
                plain_error("the bus was never granted after a command");
            end
        end
    endtask

    task automatic wait_intr(input int limit);
        int n;
        n = 0;
        while (intr == `INTR_NONE) begin
            @(posedge clk);
            n++;
            if (n > limit) begin
                plain_error("no interrupt was raised after a command");
            end
        end
    endtask

    task automatic hold_and_resolve(input logic [1:0] code);
        int hold;
        hold = 1 + int'($urandom % 8);
        repeat (hold) begin
            @(posedge clk);
            assert (intr == code)
            else value_error($sformatf("intr is %0d before resolve, expected %0d", intr, code));
        end
        intr_resolved <= 1'b1;
        @(posedge clk);
        intr_resolved <= 1'b0;
        @(posedge clk);
        assert (intr == `INTR_NONE)
        else value_error("intr not cleared one cycle after intr_resolved");
    endtask

    // a held read waits here until rd_ready.
    task automatic read_check(input logic [`WORD_SIZE-1:0] addr);
        logic [`QWORD_SIZE-1:0] expected;
        int waited;
        waited = 0;
        @(posedge clk);
        rd_en   <= 1'b1;
        rd_addr <= addr;
        @(posedge clk);
        while (!rd_ready) begin
            assert (!rd_valid) else value_error("rd_valid while the read was held off");
            waited++;
            if (waited > MAX_BLOCKS * BLK_CYCLES) begin
                plain_error("a held read was never accepted");
            end
            @(posedge clk);
        end
        expected = model[addr[2 +: IDX_W]];
        rd_en <= 1'b0;
        @(posedge clk);
        assert (rd_valid) else value_error("no rd_valid one cycle after the read");
        assert (rd_data == expected)
        else value_error($sformatf("read at %h gave %h, expected %h", addr, rd_data, expected));
    endtask

    task automatic full_readback();
        logic [`WORD_SIZE-1:0] addr;
        for (int i = 0; i < `MEM_QWORDS; i++) begin
            addr = `WORD_SIZE'($urandom) & ~`WORD_SIZE'(`MEM_QWORDS * `DMA_STEP - 1);
            addr = addr | `WORD_SIZE'(i * `DMA_STEP) | `WORD_SIZE'($urandom % 4);
            read_check(addr);
        end
    endtask

    task automatic run_copy(input logic [`WORD_SIZE-1:0] addr, input int len,
                            input bit with_read);
        int blocks;
        blocks     = len / `DMA_STEP;
        cur_addr   = addr;
        blk_count  = 0;
        dev_pulses = 0;
        issue_cmd(addr, len);
        if (with_read) begin
            wait_bg();
            read_check(addr + `WORD_SIZE'(`DMA_STEP * int'($urandom % blocks)));
        end
        wait_intr(blocks * BLK_CYCLES + 20);
        assert (intr == `INTR_DMA_END) else value_error("copy did not end with INTR_DMA_END");
        assert (dev_pulses == blocks)
        else value_error($sformatf("%0d dev_next pulses for %0d blocks", dev_pulses, blocks));
        hold_and_resolve(`INTR_DMA_END);
        for (int i = 0; i < blocks; i++) begin
            read_check(addr + `WORD_SIZE'(`DMA_STEP * i));
        end
    endtask

    task automatic run_bad_len();
        int len;
        if ($urandom % 3 == 0) begin
            len = 0;
        end else begin
            len = `DMA_STEP * int'($urandom % 8) + 1 + int'($urandom % 3);
        end
        dev_pulses = 0;
        issue_cmd(`WORD_SIZE'($urandom), len);
        wait_intr(8);
        assert (intr == `INTR_DMA_ERR)
        else value_error($sformatf("length %0d did not give INTR_DMA_ERR", len));
        repeat (2 * BLK_CYCLES) begin
            @(posedge clk);
            assert (!bg) else value_error("bus granted for a bad length");
        end
        assert (dev_pulses == 0) else value_error("dev_next pulsed for a bad length");
        hold_and_resolve(`INTR_DMA_ERR);
        full_readback();
    endtask

    task automatic run_busy_drop();
        int len_a;
        int len_b;
        logic [`WORD_SIZE-1:0] addr_a;
        logic [`WORD_SIZE-1:0] addr_b;
        len_a  = `DMA_STEP * (1 + int'($urandom % 8));
        len_b  = `DMA_STEP * (1 + int'($urandom % 8));
        addr_a = `WORD_SIZE'($urandom) & ~`WORD_SIZE'(`DMA_STEP - 1);
        addr_b = addr_a + `WORD_SIZE'(`DMA_STEP * `MEM_QWORDS / 2); // disjoint range.
        cur_addr   = addr_a;
        blk_count  = 0;
        dev_pulses = 0;
        issue_cmd(addr_a, len_a);
        wait_bg();
        issue_cmd(addr_b, len_b);
        assert (bg) else value_error("second command was not issued under a grant");
        wait_intr(len_a / `DMA_STEP * BLK_CYCLES + 20);
        assert (intr == `INTR_DMA_END) else value_error("busy copy did not end with INTR_DMA_END");
        hold_and_resolve(`INTR_DMA_END);
        repeat ((len_b / `DMA_STEP + 2) * BLK_CYCLES) begin
            @(posedge clk);
            assert (intr == `INTR_NONE && !bg)
            else value_error("a command dropped while busy started later");
        end
        assert (dev_pulses == len_a / `DMA_STEP)
        else value_error($sformatf("%0d dev_next pulses during a busy drop", dev_pulses));
        full_readback();
    endtask

    initial begin
        int kind;
        void'($urandom(46));
        dev_count     = '0;
        blk_count     = 0;
        dev_pulses    = 0;
        cur_addr      = '0;
        rst           <= 1'b1;
        cmd_req       <= 1'b0;
        cmd_addr      <= '0;
        cmd_data      <= '0;
        intr_resolved <= 1'b0;
        dev_data.raw  <= {32'd0, $urandom};
        rd_en         <= 1'b0;
        rd_addr       <= '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        assert (intr == `INTR_NONE && !bg && !rd_valid && !dev_next)
        else value_error("outputs not idle after reset");
        run_copy('0, `MEM_QWORDS * `DMA_STEP, 1'b0); // fill the whole bank first.
        for (int r = 0; r < NUM_ROUNDS; r++) begin
            kind = int'($urandom % 4);
            case (kind)
                0, 1: begin
                    run_copy(`WORD_SIZE'($urandom) & ~`WORD_SIZE'(`DMA_STEP - 1),
                             `DMA_STEP * (1 + int'($urandom % 8)), kind == 1);
                end
                2: run_bad_len();
                default: run_busy_drop();
            endcase
        end
        full_readback();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== logic/bus_arbiter.sv ====
`include "dma_consts.svh"

module bus_arbiter (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    br,
    input  logic                    rd_en,
    input  logic [`WORD_SIZE-1:0]   rd_addr,
    input  logic                    wr_en,
    input  logic [`WORD_SIZE-1:0]   wr_addr,
    output logic                    bg,
    output logic                    rd_ready,
    output logic [`WORD_SIZE-1:0]   mem_addr,
    output logic                    mem_rd,
    output logic                    mem_wr
);

    logic rd_accept;

    // cpu owns the bus whenever the dma has no grant.
    assign rd_accept = rd_en && !bg;
    assign rd_ready  = !bg;

    // grant follows br by a cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            bg <= 1'b0;
        end else if (bg) begin
            bg <= br;
        end else begin
            bg <= br && !rd_accept; // a read in flight delays the grant.
        end
    end

    // address comes from the current owner.
    always_comb begin
        if (bg) begin
            mem_addr = wr_addr;
        end else begin
            mem_addr = rd_addr;
        end
    end

    assign mem_rd = rd_accept;
    assign mem_wr = bg && wr_en;

endmodule

// ==== logic/dma_cmd_port.sv ====
`include "dma_consts.svh"

module dma_cmd_port (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cmd_req,
    input  logic [`WORD_SIZE-1:0]   cmd_addr,
    input  dma_pkg::dma_qword_u     cmd_data,
    input  logic                    busy,
    input  logic                    done,
    input  logic                    intr_resolved,
    output logic                    start,
    output logic [`WORD_SIZE-1:0]   start_addr,
    output logic [`WORD_SIZE-1:0]   start_len,
    output logic [1:0]              intr
);

    logic free;
    logic len_ok;
    logic accept;
    logic reject;

    // start is still pending in the cycle before busy rises.
    assign free   = !busy && !start;
    assign len_ok = (cmd_data.cmd.len != '0) &&
                    ((cmd_data.cmd.len % `DMA_STEP) == 0);
    assign accept = cmd_req && free && len_ok;
    assign reject = cmd_req && free && !len_ok; // busy drops are silent.

    always_ff @(posedge clk) begin
        if (rst) begin
            start <= 1'b0;
        end else begin
            start <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            start_addr <= cmd_addr;
            start_len  <= cmd_data.cmd.len;
        end
    end

    // interrupt code holds until the cpu resolves it.
    always_ff @(posedge clk) begin
        if (rst) begin
            intr <= `INTR_NONE;
        end else if (done) begin
            intr <= `INTR_DMA_END;
        end else if (reject) begin
            intr <= `INTR_DMA_ERR;
        end else if (intr_resolved) begin
            intr <= `INTR_NONE;
        end
    end

endmodule

// ==== logic/dma_consts.svh ====
`ifndef DMA_CONSTS_SVH
`define DMA_CONSTS_SVH

// address word and data quad-word widths.
`define WORD_SIZE 16
`define QWORD_SIZE 64

// words moved per block, also the address step.
`define DMA_STEP 4

// cycles from write start to its ack.
`define MEM_WR_LAT 3

// memory depth in quad-words.
`define MEM_QWORDS 64

// interrupt codes.
`define INTR_NONE 2'd0
`define INTR_DMA_END 2'd1
`define INTR_DMA_ERR 2'd2

`endif

// ==== logic/dma_engine.sv ====
`include "dma_consts.svh"

module dma_engine (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic [`WORD_SIZE-1:0]   start_addr,
    input  logic [`WORD_SIZE-1:0]   start_len,
    input  logic                    bg,
    input  dma_pkg::dma_qword_u     dev_data,
    input  logic                    wr_ack,
    output logic                    busy,
    output logic                    br,
    output logic                    wr_en,
    output logic [`WORD_SIZE-1:0]   wr_addr,
    output logic [`QWORD_SIZE-1:0]  wr_data,
    output logic                    dev_next,
    output logic                    done
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_REQ   = 2'd1;
    localparam logic [1:0] ST_WRITE = 2'd2;
    localparam logic [1:0] ST_WAIT  = 2'd3;

    localparam logic [`WORD_SIZE-1:0] STEP = `WORD_SIZE'(`DMA_STEP);

    logic [1:0]             state;
    logic [`WORD_SIZE-1:0]  target_addr;
    logic [`WORD_SIZE-1:0]  target_len;
    logic [`WORD_SIZE-1:0]  offset;
    logic                   last_blk;
    logic                   blk_acked;

    assign last_blk  = (offset == target_len - STEP);
    assign blk_acked = (state == ST_WAIT) && wr_ack;

    assign busy     = (state != ST_IDLE);
    assign wr_en    = (state == ST_WRITE); // one cycle per block.
    assign wr_addr  = target_addr + offset;
    assign wr_data  = dev_data.raw;
    assign dev_next = wr_en; // device moves to its next quad-word.
    assign done     = blk_acked && last_blk;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            br    <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= ST_REQ;
                        br    <= 1'b1;
                    end
                end
                ST_REQ: begin
                    if (bg) begin
                        state <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    state <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (wr_ack) begin
                        if (last_blk) begin
                            state <= ST_IDLE; // release the bus.
                            br    <= 1'b0;
                        end else begin
                            state <= ST_WRITE;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                    br    <= 1'b0;
                end
            endcase
        end
    end

    // target and running offset.
    always_ff @(posedge clk) begin
        if (rst) begin
            offset <= '0;
        end else if (state == ST_IDLE && start) begin
            offset <= '0;
        end else if (blk_acked && !last_blk) begin
            offset <= offset + STEP;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) begin
            target_addr <= start_addr;
            target_len  <= start_len;
        end
    end

endmodule

// ==== logic/dma_pkg.sv ====
`include "dma_consts.svh"

package dma_pkg;

    // one data word, read either as raw payload or as a dma command.
    typedef union packed {
        logic [`QWORD_SIZE-1:0] raw; // device and memory paths.
        struct packed {
            logic [`QWORD_SIZE-`WORD_SIZE-1:0] rsvd;
            logic [`WORD_SIZE-1:0] len; // length in words.
        } cmd;
    } dma_qword_u;

endpackage

// ==== logic/dma_subsystem.sv ====
`include "dma_consts.svh"

module dma_subsystem (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cmd_req,
    input  logic [`WORD_SIZE-1:0]   cmd_addr,
    input  dma_pkg::dma_qword_u     cmd_data,
    input  logic                    intr_resolved,
    input  dma_pkg::dma_qword_u     dev_data,
    input  logic                    rd_en,
    input  logic [`WORD_SIZE-1:0]   rd_addr,
    output logic [1:0]              intr,
    output logic                    dev_next,
    output logic                    rd_ready,
    output logic [`QWORD_SIZE-1:0]  rd_data,
    output logic                    rd_valid,
    output logic                    bg
);

    logic                   start;
    logic [`WORD_SIZE-1:0]  start_addr;
    logic [`WORD_SIZE-1:0]  start_len;
    logic                   busy;
    logic                   done;
    logic                   br;
    logic                   wr_en;
    logic [`WORD_SIZE-1:0]  wr_addr;
    logic [`QWORD_SIZE-1:0] wr_data;
    logic                   wr_ack;
    logic [`WORD_SIZE-1:0]  mem_addr;
    logic                   mem_rd;
    logic                   mem_wr;

    dma_cmd_port u_cmd_port (
        .clk           (clk),
        .rst           (rst),
        .cmd_req       (cmd_req),
        .cmd_addr      (cmd_addr),
        .cmd_data      (cmd_data),
        .busy          (busy),
        .done          (done),
        .intr_resolved (intr_resolved),
        .start         (start),
        .start_addr    (start_addr),
        .start_len     (start_len),
        .intr          (intr)
    );

    dma_engine u_engine (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .start_addr (start_addr),
        .start_len  (start_len),
        .bg         (bg),
        .dev_data   (dev_data),
        .wr_ack     (wr_ack),
        .busy       (busy),
        .br         (br),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .dev_next   (dev_next),
        .done       (done)
    );

    bus_arbiter u_arbiter (
        .clk      (clk),
        .rst      (rst),
        .br       (br),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .bg       (bg),
        .rd_ready (rd_ready),
        .mem_addr (mem_addr),
        .mem_rd   (mem_rd),
        .mem_wr   (mem_wr)
    );

    mem_bank u_mem (
        .clk      (clk),
        .rst      (rst),
        .mem_addr (mem_addr),
        .mem_rd   (mem_rd),
        .mem_wr   (mem_wr),
        .wr_data  (wr_data),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .wr_ack   (wr_ack)
    );

endmodule

// ==== logic/mem_bank.sv ====
`include "dma_consts.svh"

module mem_bank (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`WORD_SIZE-1:0]   mem_addr,
    input  logic                    mem_rd,
    input  logic                    mem_wr,
    input  logic [`QWORD_SIZE-1:0]  wr_data,
    output logic [`QWORD_SIZE-1:0]  rd_data,
    output logic                    rd_valid,
    output logic                    wr_ack
);

    localparam int IDX_W = $clog2(`MEM_QWORDS);
    localparam int CNT_W = $clog2(`MEM_WR_LAT + 1);

    logic [`QWORD_SIZE-1:0] mem [`MEM_QWORDS];
    logic [IDX_W-1:0]       idx;
    logic [CNT_W-1:0]       wr_cnt;

    // word address, dropping the offset within a quad-word.
    assign idx = mem_addr[2 +: IDX_W];

    always_ff @(posedge clk) begin
        if (mem_wr) begin
            mem[idx] <= wr_data;
        end
    end

    // countdown to the write ack.
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_cnt <= '0;
        end else if (mem_wr) begin
            wr_cnt <= CNT_W'(`MEM_WR_LAT);
        end else if (wr_cnt != '0) begin
            wr_cnt <= wr_cnt - 1'b1;
        end
    end

    assign wr_ack = (wr_cnt == CNT_W'(1));

    // registered read path.
    always_ff @(posedge clk) begin
        if (mem_rd) begin
            rd_data <= mem[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= mem_rd;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the dma subsystem testbench with verilator.
cd "$(dirname "$0")" || exit 1

TOP=tb_dma_subsystem
LOG=sim.log

if ! verilator --binary --timing --assert -f dma_subsystem.f --top-module "$TOP" -o "$TOP"; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
fi

if ! grep -q "TEST RESULT: PASS" "$LOG"; then
    echo "pass message not found in $LOG"
    exit 1
fi
exit 0
